//--- tile_array_pkg.sv
/*
  sizes, widths and shared types of the tile accumulator array
  grid steps are assumed nonzero, a zero step never ends the walk
  address arithmetic wraps at GBW bits, data sums wrap at DBW bits
*/
package tile_array_pkg;

	// ========================================================================
	// sizes
	// ========================================================================
	localparam int VDIM = 2;   // grid dimensions
	localparam int N_TAU = 2;  // tile units
	localparam int CSIZE = 4;  // words per cache line

	// ========================================================================
	// widths
	// ========================================================================
	localparam int WBW = 8;    // grid coordinate
	localparam int GBW = 16;   // dram word address
	localparam int DBW = 16;   // data word
	localparam int TAU_BW = (N_TAU > 1) ? $clog2(N_TAU) : 1;
	localparam int BCNT_BW = 16;  // outstanding block counter

	// ========================================================================
	// types
	// ========================================================================
	typedef logic [WBW-1:0] coord_t;
	typedef coord_t [VDIM-1:0] bofs_t;       // block offset, [0] is the fast axis
	typedef logic [GBW-1:0] gaddr_t;
	typedef logic [CSIZE-1:0][DBW-1:0] line_t;
	typedef logic [CSIZE-1:0] mask_t;        // one bit per word

endpackage

//--- line_accumulator.sv
/*
  CSIZE-word accumulator, each word wraps at DBW bits
  clear together with add loads the new line alone
*/
`timescale 1ns/1ps

module line_accumulator
	import tile_array_pkg::*;
(
	input  logic  i_clk,
	input  logic  i_arst_n,
	input  logic  i_clear,
	input  logic  i_add,
	input  line_t i_line,
	output line_t o_sum
);

line_t sum;

assign o_sum = sum;

always_ff @(posedge i_clk or negedge i_arst_n) begin
	if (!i_arst_n) begin
		sum <= '0;
	end else begin
		for (int k = 0; k < CSIZE; k++) begin
			if (i_clear) begin
				sum[k] <= i_add ? i_line[k] : '0;
			end else if (i_add) begin
				sum[k] <= sum[k] + i_line[k];  // wraps at DBW
			end
		end
	end
end

endmodule

//--- tile_dram_ctrl.sv
/*
  per-unit dram sequencer, one read outstanding at a time
  the read line is taken in the same cycle as the read-data ack
  an empty accumulation range still writes one line, all zero
  i_agrid_step is assumed nonzero when the range is not empty
*/
`timescale 1ns/1ps

module tile_dram_ctrl
	import tile_array_pkg::*;
(
	input  logic   i_clk,
	input  logic   i_arst_n,
	input  logic   i_start,
	input  gaddr_t i_read_base,
	input  coord_t i_agrid_step,
	input  coord_t i_agrid_end,
	input  logic   i_dramra_ack,
	input  logic   i_dramrd_rdy,
	input  logic   i_dramw_ack,
	output logic   o_idle,
	output logic   o_dramra_rdy,
	output gaddr_t o_dramra,
	output logic   o_dramrd_ack,
	output logic   o_acc_clear,
	output logic   o_acc_add,
	output logic   o_dramw_rdy,
	output logic   o_done
);

typedef enum logic [2:0] {
	S_IDLE,
	S_RA,    // read address
	S_RD,    // read data
	S_NEXT,  // step the accumulation index
	S_WR,
	S_DONE
} state_t;

state_t       state;
state_t       state_nxt;
coord_t       aidx;      // accumulation index
logic [WBW:0] aidx_nxt;  // one extra bit so the end compare never wraps
logic         last;

assign aidx_nxt = {1'b0, aidx} + {1'b0, i_agrid_step};
assign last     = aidx_nxt >= {1'b0, i_agrid_end};

// ============================================================================
// next state
// ============================================================================
always_comb begin
	state_nxt = state;
	case (state)
		S_IDLE: begin
			if (i_start) begin
				state_nxt = (i_agrid_end == '0) ? S_WR : S_RA;
			end
		end
		S_RA: begin
			if (i_dramra_ack) state_nxt = S_RD;
		end
		S_RD: begin
			if (i_dramrd_rdy) state_nxt = S_NEXT;
		end
		S_NEXT: begin
			state_nxt = last ? S_WR : S_RA;
		end
		S_WR: begin
			if (i_dramw_ack) state_nxt = S_DONE;
		end
		S_DONE: begin
			state_nxt = S_IDLE;
		end
		default: begin
			state_nxt = S_IDLE;
		end
	endcase
end

always_ff @(posedge i_clk or negedge i_arst_n) begin
	if (!i_arst_n) begin
		state <= S_IDLE;
		aidx  <= '0;
	end else begin
		state <= state_nxt;
		if (state == S_IDLE && i_start) begin
			aidx <= '0;
		end else if (state == S_NEXT && !last) begin
			aidx <= aidx_nxt[WBW-1:0];
		end
	end
end

// ============================================================================
// outputs
// ============================================================================
assign o_idle       = state == S_IDLE;
assign o_dramra_rdy = state == S_RA;
assign o_dramra     = i_read_base + GBW'(aidx);
assign o_dramrd_ack = (state == S_RD) && i_dramrd_rdy;
assign o_acc_add    = o_dramrd_ack;                  // sum the line as it lands
assign o_acc_clear  = (state == S_IDLE) && i_start;  // fresh sum per block
assign o_dramw_rdy  = state == S_WR;
assign o_done       = state == S_DONE;               // blkdone, one cycle

endmodule

//--- tile_accum_unit.sv
/*
  one tile unit, takes a block offset while idle and runs it to blkdone
  offset is captured on the bofs transfer and held for the whole block
*/
`timescale 1ns/1ps

module tile_accum_unit
	import tile_array_pkg::*;
(
	input  logic   i_clk,
	input  logic   i_arst_n,
	input  logic   i_bofs_rdy,
	input  bofs_t  i_bofs,
	input  coord_t i_agrid_step,
	input  coord_t i_agrid_end,
	input  coord_t i_bboundary,
	input  gaddr_t i_i0_linear,
	input  gaddr_t i_i0_pitch,
	input  gaddr_t i_o_linear,
	input  gaddr_t i_o_pitch,
	input  logic   i_dramra_ack,
	input  logic   i_dramrd_rdy,
	input  line_t  i_dramrd,
	input  logic   i_dramw_ack,
	output logic   o_bofs_ack,
	output logic   o_blkdone,
	output logic   o_dramra_rdy,
	output gaddr_t o_dramra,
	output logic   o_dramrd_ack,
	output logic   o_dramw_rdy,
	output gaddr_t o_dramwa,
	output line_t  o_dramwd,
	output mask_t  o_dramw_mask
);

bofs_t  bofs_r;
logic   idle;
logic   start;
logic   acc_clear;
logic   acc_add;
gaddr_t read_base;

assign o_bofs_ack = idle;
assign start = i_bofs_rdy && idle;

always_ff @(posedge i_clk) begin
	if (start) bofs_r <= i_bofs;
end

assign read_base = i_i0_linear + GBW'(bofs_r[1]) * i_i0_pitch + GBW'(bofs_r[0]);
assign o_dramwa  = i_o_linear + GBW'(bofs_r[1]) * i_o_pitch + GBW'(bofs_r[0]);

// words past the dim 0 boundary are not written
always_comb begin
	for (int k = 0; k < CSIZE; k++) begin
		o_dramw_mask[k] = ({1'b0, bofs_r[0]} + (WBW+1)'(k)) < {1'b0, i_bboundary};
	end
end

tile_dram_ctrl u_ctrl (
	.i_clk        (i_clk),
	.i_arst_n     (i_arst_n),
	.i_start      (start),
	.i_read_base  (read_base),
	.i_agrid_step (i_agrid_step),
	.i_agrid_end  (i_agrid_end),
	.i_dramra_ack (i_dramra_ack),
	.i_dramrd_rdy (i_dramrd_rdy),
	.i_dramw_ack  (i_dramw_ack),
	.o_idle       (idle),
	.o_dramra_rdy (o_dramra_rdy),
	.o_dramra     (o_dramra),
	.o_dramrd_ack (o_dramrd_ack),
	.o_acc_clear  (acc_clear),
	.o_acc_add    (acc_add),
	.o_dramw_rdy  (o_dramw_rdy),
	.o_done       (o_blkdone)
);

line_accumulator u_acc (
	.i_clk    (i_clk),
	.i_arst_n (i_arst_n),
	.i_clear  (acc_clear),
	.i_add    (acc_add),
	.i_line   (i_dramrd),
	.o_sum    (o_dramwd)
);

endmodule

//--- block_looper.sv
/*
  walks the block grid with dim 0 fastest and hands offsets to idle units
  the lowest idle unit gets the next offset, units must ack while idle
  src ack is a one-cycle pulse once every handed-out block has finished
*/
`timescale 1ns/1ps

module block_looper
	import tile_array_pkg::*;
(
	input  logic             i_clk,
	input  logic             i_arst_n,
	input  logic             i_src_rdy,
	input  bofs_t            i_bgrid_step,
	input  bofs_t            i_bgrid_end,
	input  logic [N_TAU-1:0] i_bofs_acks,
	input  logic [N_TAU-1:0] i_blkdones,
	output logic             o_src_ack,
	output logic [N_TAU-1:0] o_bofs_rdys,
	output bofs_t            o_bofs
);

logic               active;     // run in progress
logic               grid_done;  // every offset handed out
bofs_t              cnt;
bofs_t              cnt_nxt;
logic               wrap;
logic [WBW:0]       c_sum;
logic               empty;
logic [N_TAU-1:0]   busy;
logic [N_TAU-1:0]   xfers;
logic               xfer;
logic [BCNT_BW-1:0] pending;
logic [BCNT_BW-1:0] pending_nxt;
logic [TAU_BW:0]    n_done;
logic [TAU_BW-1:0]  sel;
logic               sel_ok;
logic               start;
logic               fin;

// ============================================================================
// unit selection and handshake
// ============================================================================
always_comb begin
	sel = '0;
	sel_ok = 1'b0;
	for (int k = N_TAU-1; k >= 0; k--) begin  // descending, lowest free wins
		if (!busy[k]) begin
			sel = TAU_BW'(k);
			sel_ok = 1'b1;
		end
	end
end

always_comb begin
	for (int k = 0; k < N_TAU; k++) begin
		o_bofs_rdys[k] = active && !grid_done && sel_ok && (sel == TAU_BW'(k));
	end
end

assign o_bofs = cnt;
assign xfers  = o_bofs_rdys & i_bofs_acks;
assign xfer   = |xfers;

// ============================================================================
// grid counter, carry from dim 0 upward
// ============================================================================
always_comb begin
	cnt_nxt = cnt;
	wrap = 1'b1;
	c_sum = '0;
	for (int d = 0; d < VDIM; d++) begin
		if (wrap) begin
			c_sum = {1'b0, cnt[d]} + {1'b0, i_bgrid_step[d]};
			if (c_sum < {1'b0, i_bgrid_end[d]}) begin
				cnt_nxt[d] = c_sum[WBW-1:0];
				wrap = 1'b0;
			end else begin
				cnt_nxt[d] = '0;
			end
		end
	end
end

always_comb begin
	empty = 1'b0;
	for (int d = 0; d < VDIM; d++) begin
		if (i_bgrid_end[d] == '0) empty = 1'b1;
	end
end

// completion bookkeeping
always_comb begin
	n_done = '0;
	for (int k = 0; k < N_TAU; k++) begin
		n_done = n_done + (TAU_BW+1)'(i_blkdones[k]);
	end
end

assign pending_nxt = pending + BCNT_BW'(xfer) - BCNT_BW'(n_done);
assign start = i_src_rdy && !active && !o_src_ack;  // no restart in the ack cycle
assign fin = active && grid_done && (pending_nxt == '0);

always_ff @(posedge i_clk or negedge i_arst_n) begin
	if (!i_arst_n) begin
		active    <= 1'b0;
		grid_done <= 1'b0;
		cnt       <= '0;
		busy      <= '0;
		pending   <= '0;
		o_src_ack <= 1'b0;
	end else begin
		o_src_ack <= fin;
		busy      <= (busy & ~i_blkdones) | xfers;
		pending   <= pending_nxt;
		if (start) begin
			active    <= 1'b1;
			cnt       <= '0;
			grid_done <= empty;
		end else if (fin) begin
			active <= 1'b0;
		end else if (xfer) begin
			cnt <= cnt_nxt;
			if (wrap) grid_done <= 1'b1;
		end
	end
end

endmodule

//--- tile_array_top.sv
/*
  block-parallel tile accumulator, one looper feeding N_TAU units
  each unit owns its dram read-address, read-data and write ports
  run configuration must stay stable while i_src_rdy is high
*/
`timescale 1ns/1ps

module tile_array_top
	import tile_array_pkg::*;
(
	input  logic             i_clk,
	input  logic             i_arst_n,
	input  logic             i_src_rdy,
	output logic             o_src_ack,
	input  bofs_t            i_bgrid_step,   // block shape
	input  bofs_t            i_bgrid_end,    // block shape times block count
	input  coord_t           i_agrid_step,
	input  coord_t           i_agrid_end,
	input  coord_t           i_bboundary,    // dim 0 limit for the write mask
	input  gaddr_t           i_i0_linear,
	input  gaddr_t           i_i0_pitch,
	input  gaddr_t           i_o_linear,
	input  gaddr_t           i_o_pitch,
	output logic [N_TAU-1:0] o_dramra_rdy,
	input  logic [N_TAU-1:0] i_dramra_ack,
	output gaddr_t           o_dramras [N_TAU],
	input  logic [N_TAU-1:0] i_dramrd_rdy,
	output logic [N_TAU-1:0] o_dramrd_ack,
	input  line_t            i_dramrds [N_TAU],
	output logic [N_TAU-1:0] o_dramw_rdy,
	input  logic [N_TAU-1:0] i_dramw_ack,
	output gaddr_t           o_dramwas [N_TAU],
	output line_t            o_dramwds [N_TAU],
	output mask_t            o_dramw_masks [N_TAU]
);

logic [N_TAU-1:0] blk_tau_bofs_rdys;
logic [N_TAU-1:0] blk_tau_bofs_acks;
bofs_t            blk_tau_bofs;      // shared by all units, rdy picks the taker
logic [N_TAU-1:0] tau_blk_dones;

block_looper u_pbl (
	.i_clk        (i_clk),
	.i_arst_n     (i_arst_n),
	.i_src_rdy    (i_src_rdy),
	.i_bgrid_step (i_bgrid_step),
	.i_bgrid_end  (i_bgrid_end),
	.i_bofs_acks  (blk_tau_bofs_acks),
	.i_blkdones   (tau_blk_dones),
	.o_src_ack    (o_src_ack),
	.o_bofs_rdys  (blk_tau_bofs_rdys),
	.o_bofs       (blk_tau_bofs)
);

genvar i;
generate
	for (i = 0; i < N_TAU; i++) begin : g_tau
		tile_accum_unit u_tau (
			.i_clk        (i_clk),
			.i_arst_n     (i_arst_n),
			.i_bofs_rdy   (blk_tau_bofs_rdys[i]),
			.i_bofs       (blk_tau_bofs),
			.i_agrid_step (i_agrid_step),
			.i_agrid_end  (i_agrid_end),
			.i_bboundary  (i_bboundary),
			.i_i0_linear  (i_i0_linear),
			.i_i0_pitch   (i_i0_pitch),
			.i_o_linear   (i_o_linear),
			.i_o_pitch    (i_o_pitch),
			.i_dramra_ack (i_dramra_ack[i]),
			.i_dramrd_rdy (i_dramrd_rdy[i]),
			.i_dramrd     (i_dramrds[i]),
			.i_dramw_ack  (i_dramw_ack[i]),
			.o_bofs_ack   (blk_tau_bofs_acks[i]),
			.o_blkdone    (tau_blk_dones[i]),
			.o_dramra_rdy (o_dramra_rdy[i]),
			.o_dramra     (o_dramras[i]),
			.o_dramrd_ack (o_dramrd_ack[i]),
			.o_dramw_rdy  (o_dramw_rdy[i]),
			.o_dramwa     (o_dramwas[i]),
			.o_dramwd     (o_dramwds[i]),
			.o_dramw_mask (o_dramw_masks[i])
		);
	end
endgenerate

endmodule

//--- tb_clk_gen.sv
/*
  testbench clock and reset, 8 ns period
  reset is held low for 3 rising edges and released on a falling edge
*/
`timescale 1ns/1ps

module tb_clk_gen (
	output logic o_clk,
	output logic o_arst_n
);

initial begin
	o_clk = 1'b0;
	forever #4 o_clk = ~o_clk;
end

initial begin
	o_arst_n = 1'b0;
	repeat (3) @(posedge o_clk);
	@(negedge o_clk);
	o_arst_n = 1'b1;
end

endmodule

//--- tb_dram_model.sv
/*
  dram model for every unit, address A returns words A*3+k+1
  each rdy or ack comes after 0 to 3 cycles of random delay
  outputs change on the falling clock edge only
*/
`timescale 1ns/1ps

module tb_dram_model
	import tile_array_pkg::*;
(
	input  logic             i_clk,
	input  logic             i_arst_n,
	input  logic [N_TAU-1:0] i_dramra_rdy,
	input  gaddr_t           i_dramras [N_TAU],
	output logic [N_TAU-1:0] o_dramra_ack,
	output logic [N_TAU-1:0] o_dramrd_rdy,
	output line_t            o_dramrds [N_TAU],
	input  logic [N_TAU-1:0] i_dramrd_ack,
	input  logic [N_TAU-1:0] i_dramw_rdy,
	output logic [N_TAU-1:0] o_dramw_ack
);

localparam logic [31:0] SEED = 32'd66146;
localparam int HOLD_LIMIT = 64;  // cycles a read line waits for its ack

function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	return y ^ (y << 5);
endfunction

function automatic line_t line_at(input gaddr_t addr);
	line_t l;
	for (int k = 0; k < CSIZE; k++) begin
		l[k] = DBW'(addr * 3 + k + 1);
	end
	return l;
endfunction

for (genvar u = 0; u < N_TAU; u++) begin : g_port
	logic  ra_ack;
	logic  rd_rdy;
	line_t rd_line;
	logic  w_ack;

	assign o_dramra_ack[u] = ra_ack;
	assign o_dramrd_rdy[u] = rd_rdy;
	assign o_dramrds[u]    = rd_line;
	assign o_dramw_ack[u]  = w_ack;

	initial begin
		logic [31:0] rs;
		gaddr_t      addr;
		int          n;
		rs = SEED + u;  // unit 0 runs on the bare seed
		ra_ack = 1'b0;
		rd_rdy = 1'b0;
		rd_line = '0;
		w_ack = 1'b0;
		forever begin
			@(negedge i_clk);
			if (i_arst_n && i_dramra_rdy[u]) begin
				rs = xorshift(rs);
				repeat (rs[1:0]) @(negedge i_clk);
				addr = i_dramras[u];  // held by the dut until the transfer
				ra_ack = 1'b1;
				@(negedge i_clk);
				ra_ack = 1'b0;
				rs = xorshift(rs);
				repeat (rs[1:0]) @(negedge i_clk);
				rd_line = line_at(addr);
				rd_rdy = 1'b1;
				n = 0;
				@(posedge i_clk);
				while (!i_dramrd_ack[u] && n < HOLD_LIMIT) begin
					n++;
					@(posedge i_clk);
				end
				@(negedge i_clk);
				rd_rdy = 1'b0;
			end else if (i_arst_n && i_dramw_rdy[u]) begin
				rs = xorshift(rs);
				repeat (rs[1:0]) @(negedge i_clk);
				w_ack = 1'b1;
				@(negedge i_clk);
				w_ack = 1'b0;
			end
		end
	end
end

endmodule

//--- tb_tile_array.sv
/*
  testbench for the tile accumulator array, one grid setup per table row
  expected reads and writes follow the address, sum and mask rules of the design
  every wait is bounded in cycles, a timeout counts as an error
*/
`timescale 1ns/1ps

module tb_tile_array
	import tile_array_pkg::*;
();

localparam int N_ROWS = 6;
localparam int RUN_LIMIT = 6000;  // cycles per run
localparam int RST_LIMIT = 20;

typedef struct packed {
	coord_t bstep0, bstep1, bend0, bend1;
	coord_t astep, aend, bound;
	gaddr_t i0_lin, i0_pitch, o_lin, o_pitch;
} run_t;

logic clk, arst_n, src_rdy, src_ack;
bofs_t bgrid_step, bgrid_end;
coord_t agrid_step, agrid_end, bboundary;
gaddr_t i0_linear, i0_pitch, o_linear, o_pitch;
logic [N_TAU-1:0] dramra_rdy, dramra_ack, dramrd_rdy, dramrd_ack, dramw_rdy, dramw_ack;
gaddr_t dramras [N_TAU];
gaddr_t dramwas [N_TAU];
line_t dramrds [N_TAU];
line_t dramwds [N_TAU];
mask_t dramw_masks [N_TAU];

run_t rows [N_ROWS];
gaddr_t exp_addr [$];  // scoreboard, one entry per block
line_t exp_data [$];
mask_t exp_mask [$];
bit exp_hit [$];
gaddr_t exp_raddr [$];  // one entry per accumulation step, repeats allowed
bit exp_rhit [$];
int n_val_err, n_other_err, n_reads, n_writes;
logic [N_TAU-1:0] used;

tb_clk_gen u_clk (.o_clk(clk), .o_arst_n(arst_n));

tile_array_top i_dut (
	.i_clk(clk), .i_arst_n(arst_n), .i_src_rdy(src_rdy), .o_src_ack(src_ack),
	.i_bgrid_step(bgrid_step), .i_bgrid_end(bgrid_end),
	.i_agrid_step(agrid_step), .i_agrid_end(agrid_end), .i_bboundary(bboundary),
	.i_i0_linear(i0_linear), .i_i0_pitch(i0_pitch),
	.i_o_linear(o_linear), .i_o_pitch(o_pitch),
	.o_dramra_rdy(dramra_rdy), .i_dramra_ack(dramra_ack), .o_dramras(dramras),
	.i_dramrd_rdy(dramrd_rdy), .o_dramrd_ack(dramrd_ack), .i_dramrds(dramrds),
	.o_dramw_rdy(dramw_rdy), .i_dramw_ack(dramw_ack), .o_dramwas(dramwas),
	.o_dramwds(dramwds), .o_dramw_masks(dramw_masks)
);

tb_dram_model u_dram (
	.i_clk(clk), .i_arst_n(arst_n),
	.i_dramra_rdy(dramra_rdy), .i_dramras(dramras), .o_dramra_ack(dramra_ack),
	.o_dramrd_rdy(dramrd_rdy), .o_dramrds(dramrds), .i_dramrd_ack(dramrd_ack),
	.i_dramw_rdy(dramw_rdy), .o_dramw_ack(dramw_ack)
);

// ============================================================================
// expected results
// ============================================================================
function automatic logic [DBW-1:0] dram_word(input gaddr_t addr, input int k);
	return DBW'(addr * 3 + k + 1);
endfunction

task automatic build_expected(input run_t row, output int n_blk);
	gaddr_t ra;
	line_t  acc;
	mask_t  m;
	exp_addr.delete();
	exp_data.delete();
	exp_mask.delete();
	exp_hit.delete();
	exp_raddr.delete();
	exp_rhit.delete();
	n_blk = 0;
	for (int b1 = 0; b1 < row.bend1; b1 += row.bstep1) begin
		for (int b0 = 0; b0 < row.bend0; b0 += row.bstep0) begin  // dim 0 fastest
			acc = '0;
			for (int a = 0; a < row.aend; a += row.astep) begin
				ra = GBW'(row.i0_lin + b1 * row.i0_pitch + b0 + a);
				exp_raddr.push_back(ra);
				exp_rhit.push_back(1'b0);
				for (int k = 0; k < CSIZE; k++) begin
					acc[k] = acc[k] + dram_word(ra, k);  // wraps at DBW
				end
			end
			for (int k = 0; k < CSIZE; k++) begin
				m[k] = (b0 + k) < row.bound;
			end
			exp_addr.push_back(GBW'(row.o_lin + b1 * row.o_pitch + b0));
			exp_data.push_back(acc);
			exp_mask.push_back(m);
			exp_hit.push_back(1'b0);
			n_blk++;
		end
	end
endtask

// ============================================================================
// checks
// ============================================================================
task automatic check_read(input int u, input gaddr_t ra);
	int idx;
	idx = -1;
	for (int i = 0; i < exp_raddr.size(); i++) begin
		if (idx < 0 && exp_raddr[i] == ra && !exp_rhit[i]) idx = i;
	end
	assert (idx >= 0) else begin
		n_val_err++;
		$display("** Error o_dramras[%0d]: got %h, not an expected read address", u, ra);
	end
	if (idx >= 0) exp_rhit[idx] = 1'b1;
	n_reads++;
endtask

task automatic check_write(input int u, input gaddr_t wa, input line_t wd,
	input mask_t wm);
	int idx;
	idx = -1;
	for (int i = 0; i < exp_addr.size(); i++) begin
		if (exp_addr[i] == wa) idx = i;
	end
	assert (idx >= 0) else begin
		n_other_err++;
		$display("unit %0d wrote to address %h, which no block of this run owns", u, wa);
	end
	if (idx >= 0) begin
		assert (!exp_hit[idx]) else begin
			n_other_err++;
			$display("address %h was written more than once", wa);
		end
		assert (wm == exp_mask[idx]) else begin
			n_val_err++;
			$display("** Error o_dramw_masks[%0d] at %h: got %h, exp %h",
				u, wa, wm, exp_mask[idx]);
		end
		for (int j = 0; j < CSIZE; j++) begin
			if (exp_mask[idx][j]) begin  // masked lanes are don't care
				assert (wd[j] == exp_data[idx][j]) else begin
					n_val_err++;
					$display("** Error o_dramwds[%0d][%0d] at %h: got %h, exp %h",
						u, j, wa, wd[j], exp_data[idx][j]);
				end
			end
		end
		exp_hit[idx] = 1'b1;
	end
	used[u] = 1'b1;
	n_writes++;
endtask

task automatic check_run(input int r, input int n_blk);
	assert (n_writes == n_blk) else begin
		n_other_err++;
		$display("run %0d: %0d writes before src ack, %0d expected", r, n_writes, n_blk);
	end
	for (int i = 0; i < exp_addr.size(); i++) begin
		assert (exp_hit[i]) else begin
			n_other_err++;
			$display("run %0d: address %h not written before src ack", r, exp_addr[i]);
		end
	end
	if (n_blk >= 2) begin
		assert (&used) else begin
			n_other_err++;
			$display("run %0d: not every unit took a block", r);
		end
	end
	assert (n_reads == exp_raddr.size()) else begin
		n_other_err++;
		$display("run %0d: %0d dram reads before src ack, %0d expected",
			r, n_reads, exp_raddr.size());
	end
endtask

task automatic load_table();
	// bstep0 bstep1 bend0 bend1 astep aend bound  i0_lin i0_pitch o_lin o_pitch
	rows[0] = {8'd4, 8'd1, 8'd4, 8'd1, 8'd1, 8'd1, 8'd8,
		16'h0100, 16'h0040, 16'h2000, 16'h0040};  // single block
	rows[1] = {8'd4, 8'd2, 8'd16, 8'd6, 8'd1, 8'd1, 8'd16,
		16'h0300, 16'h0080, 16'h4000, 16'h0020};  // 12 blocks
	rows[2] = {8'd4, 8'd1, 8'd8, 8'd2, 8'd2, 8'd9, 8'd8,
		16'h5550, 16'h0020, 16'h6000, 16'h0010};  // 5 steps, sums wrap
	rows[3] = {8'd4, 8'd1, 8'd12, 8'd1, 8'd3, 8'd7, 8'd10,
		16'h1234, 16'h0100, 16'h7000, 16'h0000};  // boundary cuts the last block
	rows[4] = {8'd4, 8'd1, 8'd0, 8'd1, 8'd1, 8'd1, 8'd8,
		16'h0100, 16'h0040, 16'h2000, 16'h0040};  // empty grid
	rows[5] = {8'd4, 8'd3, 8'd32, 8'd9, 8'd1, 8'd3, 8'd30,
		16'hff00, 16'h0033, 16'h8000, 16'h0040};  // 24 blocks, read address wraps
endtask

// write and read transfers, seen before the edge updates the dut
always @(posedge clk) begin
	for (int k = 0; k < N_TAU; k++) begin
		if (dramra_rdy[k] && dramra_ack[k]) check_read(k, dramras[k]);
		if (dramw_rdy[k] && dramw_ack[k]) begin
			check_write(k, dramwas[k], dramwds[k], dramw_masks[k]);
		end
	end
end

// ============================================================================
// run loop
// ============================================================================
initial begin
	int cyc;
	int n_blk;
	bit timed_out;
	src_rdy = 1'b0;
	bgrid_step = '0;
	bgrid_end = '0;
	agrid_step = '0;
	agrid_end = '0;
	bboundary = '0;
	i0_linear = '0;
	i0_pitch = '0;
	o_linear = '0;
	o_pitch = '0;
	n_val_err = 0;
	n_other_err = 0;
	n_reads = 0;
	n_writes = 0;
	used = '0;
	timed_out = 1'b0;
	load_table();
	cyc = 0;
	while (arst_n !== 1'b1 && cyc < RST_LIMIT) begin
		@(negedge clk);
		cyc++;
	end
	if (arst_n !== 1'b1) begin
		timed_out = 1'b1;
		n_other_err++;
		$display("reset was not released within %0d cycles", RST_LIMIT);
	end else begin
		@(negedge clk);
		assert ({src_ack, dramra_rdy, dramrd_ack, dramw_rdy} === '0) else begin
			n_val_err++;
			$display("** Error after reset: o_src_ack %h o_dramra_rdy %h %s",
				src_ack, dramra_rdy, "");
			$display("** Error after reset: o_dramrd_ack %h o_dramw_rdy %h, exp 0",
				dramrd_ack, dramw_rdy);
		end
	end
	for (int r = 0; r < N_ROWS && !timed_out; r++) begin
		build_expected(rows[r], n_blk);
		n_reads = 0;
		n_writes = 0;
		used = '0;
		@(negedge clk);
		bgrid_step[0] = rows[r].bstep0;
		bgrid_step[1] = rows[r].bstep1;
		bgrid_end[0] = rows[r].bend0;
		bgrid_end[1] = rows[r].bend1;
		agrid_step = rows[r].astep;
		agrid_end = rows[r].aend;
		bboundary = rows[r].bound;
		i0_linear = rows[r].i0_lin;
		i0_pitch = rows[r].i0_pitch;
		o_linear = rows[r].o_lin;
		o_pitch = rows[r].o_pitch;
		src_rdy = 1'b1;
		cyc = 0;
		@(negedge clk);
		while (!src_ack && cyc < RUN_LIMIT) begin
			@(negedge clk);
			cyc++;
		end
		src_rdy = 1'b0;
		if (!src_ack) begin
			timed_out = 1'b1;
			n_other_err++;
			$display("run %0d: no src ack within %0d cycles", r, RUN_LIMIT);
		end else begin
			check_run(r, n_blk);
			@(negedge clk);
			assert (!src_ack) else begin  // ack is a single-cycle pulse
				n_val_err++;
				$display("** Error o_src_ack: got %h one cycle after the ack, exp 0",
					src_ack);
			end
		end
	end
	$display("checks done: %0d value errors, %0d other errors", n_val_err, n_other_err);
	if (n_val_err + n_other_err == 0) begin
		$display("test passed");
	end else begin
		$display("test failed");
	end
	$finish;
end

endmodule

//--- tile_array.f
tile_array_pkg.sv
line_accumulator.sv
tile_dram_ctrl.sv
tile_accum_unit.sv
block_looper.sv
tile_array_top.sv
tb_clk_gen.sv
tb_dram_model.sv
tb_tile_array.sv
